// ==== src/ad9228_consts.svh ====
/* ad9228 constants
   widths and counts shared by the serial front end and the sample buffer
   of the single channel reader */
`ifndef AD9228_CONSTS_SVH
`define AD9228_CONSTS_SVH

// converter word and serial framing
`define ADC_SAMPLE_W     12 // bits in one converter sample
`define ADC_BITS_PER_DCO 2  // ddr delivers two bits per dco period
`define ADC_FCO_HALF     3  // bit pairs spent at each fco level

// sample buffer and clock crossings
`define FIFO_DEPTH_LOG2  4  // sixteen words of storage
`define SYNC_STAGES      2  // flops in every synchronizer chain

// one word takes 2 * ADC_FCO_HALF dco periods on the wire
// so fco toggles every ADC_FCO_HALF periods

`endif

// ==== src/adc_pkg.sv ====
/* adc_pkg
   types on the converter side of the reader, the sample word carried from
   the serial window to the buffer and the states of the frame tracker */
`include "ad9228_consts.svh"

package adc_pkg;

    // one converter word with the first bit on the wire at the msb
    typedef logic [`ADC_SAMPLE_W-1:0] sample_t;

    // states of the frame tracker
    // the tracker only strobes words while it sits in LOCKED
    typedef enum logic [1:0] {
        HUNT,   // waiting for fco to go high after a low pair
        ALIGN,  // checking the high and low halves before trusting the frame
        LOCKED  // in frame with one strobe per word
    } frame_state_e;

    // a bad fco pair in ALIGN or LOCKED sends the tracker back to HUNT

endpackage

// ==== src/fifo_pkg.sv ====
/* fifo_pkg
   types on the buffer side of the reader, the memory address and the
   pointers that walk the sample memory in binary and gray form */
`include "ad9228_consts.svh"

package fifo_pkg;

    // address into the sample memory
    typedef logic [`FIFO_DEPTH_LOG2-1:0] fifo_addr_t;

    // the extra top bit tells a full memory from an empty one
    // the same vector holds either the binary or the gray form
    typedef logic [`FIFO_DEPTH_LOG2:0] fifo_ptr_t;

endpackage

// ==== src/serial_shifter.sv ====
/* serial_shifter
   turns the lvds data pair of one converter channel into a single bit,
   captures it on both dco edges and keeps the newest twelve bits as a
   shift window in the dco domain */
`timescale 1ns/1ns
`include "ad9228_consts.svh"

module serial_shifter (
    input  logic             dco,        // ddr bit clock from the converter
    input  logic             arst_n,
    input  logic             din_p,      // data pair, msb first
    input  logic             din_n,
    output adc_pkg::sample_t shift_word  // newest bit at the lsb
);

    logic din_se;    // data pair resolved to one bit
    logic fall_bit;  // bit taken on the falling edge

    // p high with n low reads as one
    // a pair sitting at equal levels reads as zero
    assign din_se = din_p & ~din_n;

    // the falling edge carries the earlier bit of each pair
    always_ff @(negedge dco or negedge arst_n) begin
        if (!arst_n) begin
            fall_bit <= 1'b0;
        end else begin
            fall_bit <= din_se;  // held until the next rising edge shifts it in
        end
    end

    // two bits enter per rising edge with the falling-edge bit ahead of
    // the bit seen on this edge
    always_ff @(posedge dco or negedge arst_n) begin
        if (!arst_n) begin
            shift_word <= '0;
        end else begin
            shift_word <= {shift_word[`ADC_SAMPLE_W-`ADC_BITS_PER_DCO-1:0], fall_bit, din_se};
        end
    end

    // after the sixth pair of a word the window holds the whole word
    // and the frame tracker strobes in that same cycle

endmodule

// ==== src/frame_tracker.sv ====
/* frame_tracker
   samples fco on both dco edges, finds word boundaries and runs the lock
   state machine, pulsing word_strobe once per framed word */
`timescale 1ns/1ns
`include "ad9228_consts.svh"

module frame_tracker (
    input  logic dco,
    input  logic arst_n,
    input  logic fco,          // frame clock, high for the first half of a word
    output logic word_strobe,  // window holds a complete word this cycle
    output logic locked
);

    localparam logic [2:0] HIGH_PAIRS = 3'(`ADC_FCO_HALF);         // pairs with fco high
    localparam logic [2:0] LAST_PAIR  = 3'(2 * `ADC_FCO_HALF - 1);  // index of the final pair

    adc_pkg::frame_state_e state;
    logic       fco_fall;     // fco taken on the falling edge
    logic       pair_hi;      // both halves of this pair high
    logic       pair_lo;      // both halves of this pair low
    logic       prev_lo;      // previous pair was low
    logic [2:0] pair_idx;     // index of the last pair shifted in
    logic [2:0] next_idx;
    logic       pair_ok;      // this pair matches the level expected at next_idx
    logic       first_frame;  // ALIGN is still inside the boundary frame

    always_ff @(negedge dco or negedge arst_n) begin
        if (!arst_n) begin
            fco_fall <= 1'b0;
        end else begin
            fco_fall <= fco;
        end
    end

    // a pair is the falling sample plus the level seen at the rising edge
    assign pair_hi  = fco_fall & fco;
    assign pair_lo  = ~fco_fall & ~fco;
    assign next_idx = (pair_idx == LAST_PAIR) ? 3'd0 : pair_idx + 3'd1;
    assign pair_ok  = (next_idx < HIGH_PAIRS) ? pair_hi : pair_lo;  // mixed pairs always fail
    assign locked   = (state == adc_pkg::LOCKED);

    always_ff @(posedge dco or negedge arst_n) begin
        if (!arst_n) begin
            state       <= adc_pkg::HUNT;
            pair_idx    <= '0;
            first_frame <= 1'b0;
            prev_lo     <= 1'b0;
            word_strobe <= 1'b0;
        end else begin
            prev_lo     <= pair_lo;
            word_strobe <= 1'b0;  // strobe lasts one dco cycle
            case (state)
                adc_pkg::HUNT: begin
                    // boundary when fco rises after a clean low pair
                    if (pair_hi && prev_lo) begin
                        state       <= adc_pkg::ALIGN;
                        pair_idx    <= '0;     // boundary pair is the first of the word
                        first_frame <= 1'b1;
                    end
                end
                adc_pkg::ALIGN: begin
                    if (!pair_ok) begin
                        state <= adc_pkg::HUNT;
                    end else begin
                        pair_idx <= next_idx;
                        if (next_idx == LAST_PAIR) begin
                            if (first_frame) begin
                                first_frame <= 1'b0;  // boundary frame checked, one more to go
                            end else begin
                                state       <= adc_pkg::LOCKED;
                                word_strobe <= 1'b1;  // second frame is delivered
                            end
                        end
                    end
                end
                adc_pkg::LOCKED: begin
                    if (!pair_ok) begin
                        state <= adc_pkg::HUNT;  // a slipped frame never strobes
                    end else begin
                        pair_idx <= next_idx;
                        if (next_idx == LAST_PAIR) begin
                            word_strobe <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= adc_pkg::HUNT;
                end
            endcase
        end
    end

endmodule

// ==== src/word_assembler.sv ====
/* word_assembler
   holds each framed word in the dco domain, signals it to the clk domain
   with a toggle and writes it to the sample FIFO while read_en is high */
`timescale 1ns/1ns
`include "ad9228_consts.svh"

module word_assembler (
    input  logic             dco,
    input  logic             clk,
    input  logic             arst_n,
    input  logic             read_en,      // host gate, low drops words
    input  adc_pkg::sample_t shift_word,
    input  logic             word_strobe,
    input  logic             locked,
    output logic             wr_en,        // one clk cycle per accepted word
    output adc_pkg::sample_t wr_data
);

    logic [`SYNC_STAGES-1:0] dco_rst_sync;
    logic                    dco_rst_n;    // reset released on a dco edge
    logic [`SYNC_STAGES-1:0] clk_rst_sync;
    logic                    clk_rst_n;    // reset released on a clk edge
    adc_pkg::sample_t        hold_word;    // last framed word
    logic                    word_toggle;  // flips once per framed word
    logic [`SYNC_STAGES-1:0] toggle_sync;
    logic                    toggle_seen;  // toggle level already handled
    logic                    toggle_edge;

    // release of arst_n is brought onto each clock here
    always_ff @(posedge dco or negedge arst_n) begin
        if (!arst_n) begin
            dco_rst_sync <= '0;
        end else begin
            dco_rst_sync <= {dco_rst_sync[`SYNC_STAGES-2:0], 1'b1};
        end
    end
    assign dco_rst_n = dco_rst_sync[`SYNC_STAGES-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clk_rst_sync <= '0;
        end else begin
            clk_rst_sync <= {clk_rst_sync[`SYNC_STAGES-2:0], 1'b1};
        end
    end
    assign clk_rst_n = clk_rst_sync[`SYNC_STAGES-1];

    // the held word stays put for a whole word time of six dco cycles
    always_ff @(posedge dco) begin
        if (word_strobe && locked) begin
            hold_word <= shift_word;
        end
    end

    always_ff @(posedge dco or negedge dco_rst_n) begin
        if (!dco_rst_n) begin
            word_toggle <= 1'b0;
        end else if (word_strobe && locked) begin
            word_toggle <= ~word_toggle;  // new word ready for the clk side
        end
    end

    // clk must run at least three times the word rate to catch every flip
    assign toggle_edge = toggle_sync[`SYNC_STAGES-1] ^ toggle_seen;

    always_ff @(posedge clk or negedge clk_rst_n) begin
        if (!clk_rst_n) begin
            toggle_sync <= '0;
            toggle_seen <= 1'b0;
            wr_en       <= 1'b0;
        end else begin
            toggle_sync <= {toggle_sync[`SYNC_STAGES-2:0], word_toggle};
            toggle_seen <= toggle_sync[`SYNC_STAGES-1];
            wr_en       <= toggle_edge & read_en;  // dropped here when the host is not reading
        end
    end

    // hold_word is settled long before the toggle edge reaches this side
    always_ff @(posedge clk) begin
        if (toggle_edge) begin
            wr_data <= hold_word;
        end
    end

endmodule

// ==== src/sample_fifo_async.sv ====
/* sample_fifo_async
   sixteen word dual-clock FIFO between the clk write side and the host
   read clock, with gray pointers crossing through two-flop synchronizers */
`timescale 1ns/1ns
`include "ad9228_consts.svh"

module sample_fifo_async (
    input  logic             clk,             // write clock
    input  logic             fifo_rd_clk,     // host read clock
    input  logic             arst_n,
    input  logic             wr_en,
    input  adc_pkg::sample_t wr_data,
    output logic             fifo_full,       // clk domain
    input  logic             fifo_rd_en,
    output logic             fifo_not_empty,  // fifo_rd_clk domain
    output adc_pkg::sample_t fifo_dout
);

    localparam int DEPTH = 1 << `FIFO_DEPTH_LOG2;
    localparam int PW    = `FIFO_DEPTH_LOG2 + 1;  // pointer width

    adc_pkg::sample_t mem [DEPTH];

    fifo_pkg::fifo_ptr_t                     wr_bin;
    fifo_pkg::fifo_ptr_t                     wr_bin_next;
    fifo_pkg::fifo_ptr_t                     wr_gray;
    fifo_pkg::fifo_ptr_t                     wr_gray_next;
    fifo_pkg::fifo_ptr_t                     rd_bin;
    fifo_pkg::fifo_ptr_t                     rd_bin_next;
    fifo_pkg::fifo_ptr_t                     rd_gray;
    fifo_pkg::fifo_ptr_t                     rd_gray_next;
    fifo_pkg::fifo_ptr_t [`SYNC_STAGES-1:0]  rd_gray_sync;  // read pointer on the clk side
    fifo_pkg::fifo_ptr_t [`SYNC_STAGES-1:0]  wr_gray_sync;  // write pointer on the read side
    fifo_pkg::fifo_ptr_t                     full_match;
    fifo_pkg::fifo_addr_t                    wr_addr;
    fifo_pkg::fifo_addr_t                    rd_addr;
    logic                                    wr_fire;
    logic                                    rd_fire;
    logic [`SYNC_STAGES-1:0]                 rd_rst_sync;
    logic                                    rd_rst_n;

    // neighbouring gray codes differ in one bit so a crossing sees old or new
    function automatic fifo_pkg::fifo_ptr_t bin2gray(input fifo_pkg::fifo_ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    // write side
    assign wr_fire      = wr_en & ~fifo_full;  // writes while full vanish
    assign wr_addr      = wr_bin[`FIFO_DEPTH_LOG2-1:0];
    assign wr_bin_next  = wr_bin + {{(PW-1){1'b0}}, wr_fire};
    assign wr_gray_next = bin2gray(wr_bin_next);

    // full when the writer is one lap ahead, top two gray bits inverted
    assign full_match = {~rd_gray_sync[`SYNC_STAGES-1][PW-1:PW-2],
                         rd_gray_sync[`SYNC_STAGES-1][PW-3:0]};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_bin       <= '0;
            wr_gray      <= '0;
            rd_gray_sync <= '0;
            fifo_full    <= 1'b0;
        end else begin
            wr_bin       <= wr_bin_next;
            wr_gray      <= wr_gray_next;
            rd_gray_sync <= {rd_gray_sync[`SYNC_STAGES-2:0], rd_gray};
            fifo_full    <= (wr_gray_next == full_match);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read side with its own reset release
    always_ff @(posedge fifo_rd_clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_rst_sync <= '0;
        end else begin
            rd_rst_sync <= {rd_rst_sync[`SYNC_STAGES-2:0], 1'b1};
        end
    end
    assign rd_rst_n = rd_rst_sync[`SYNC_STAGES-1];

    assign rd_fire      = fifo_rd_en & fifo_not_empty;  // reads on empty are ignored
    assign rd_addr      = rd_bin[`FIFO_DEPTH_LOG2-1:0];
    assign rd_bin_next  = rd_bin + {{(PW-1){1'b0}}, rd_fire};
    assign rd_gray_next = bin2gray(rd_bin_next);

    always_ff @(posedge fifo_rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            rd_bin         <= '0;
            rd_gray        <= '0;
            wr_gray_sync   <= '0;
            fifo_not_empty <= 1'b0;
            fifo_dout      <= '0;
        end else begin
            rd_bin         <= rd_bin_next;
            rd_gray        <= rd_gray_next;
            wr_gray_sync   <= {wr_gray_sync[`SYNC_STAGES-2:0], wr_gray};
            fifo_not_empty <= (rd_gray_next != wr_gray_sync[`SYNC_STAGES-1]);
            if (rd_fire) begin
                fifo_dout <= mem[rd_addr];  // head word shows one cycle after the read
            end
        end
    end

endmodule

// ==== src/ad9228_single_ch_read.sv ====
/* ad9228_single_ch_read
   reads one serial lvds channel of the converter, frames its words on dco
   and buffers them for a host on its own read clock */
`timescale 1ns/1ns

module ad9228_single_ch_read (
    input  logic             clk,             // system clock, fast against the word rate
    input  logic             arst_n,
    input  logic             read_en,         // low drops incoming words
    input  logic             din_p,
    input  logic             din_n,
    input  logic             fco,
    input  logic             dco,
    input  logic             fifo_rd_en,
    input  logic             fifo_rd_clk,
    output logic             fifo_not_empty,
    output logic             fifo_full,
    output adc_pkg::sample_t fifo_dout
);

    adc_pkg::sample_t shift_word;   // serial window in the dco domain
    logic             word_strobe;  // window holds a framed word
    logic             locked;
    logic             wr_en;        // clk domain write into the FIFO
    adc_pkg::sample_t wr_data;

    serial_shifter shifter0 (
        .dco        (dco),
        .arst_n     (arst_n),
        .din_p      (din_p),
        .din_n      (din_n),
        .shift_word (shift_word)
    );

    // runs beside the shifter on the same dco edges
    frame_tracker tracker0 (
        .dco         (dco),
        .arst_n      (arst_n),
        .fco         (fco),
        .word_strobe (word_strobe),
        .locked      (locked)
    );

    word_assembler assembler0 (
        .dco         (dco),
        .clk         (clk),
        .arst_n      (arst_n),
        .read_en     (read_en),
        .shift_word  (shift_word),
        .word_strobe (word_strobe),
        .locked      (locked),
        .wr_en       (wr_en),
        .wr_data     (wr_data)
    );

    sample_fifo_async fifo0 (
        .clk            (clk),
        .fifo_rd_clk    (fifo_rd_clk),
        .arst_n         (arst_n),
        .wr_en          (wr_en),
        .wr_data        (wr_data),
        .fifo_full      (fifo_full),
        .fifo_rd_en     (fifo_rd_en),
        .fifo_not_empty (fifo_not_empty),
        .fifo_dout      (fifo_dout)
    );

endmodule

// ==== bench/tb_ad9228_single_ch_read.sv ====
/* tb_ad9228_single_ch_read
   converter model, host reader and self-checks for the single channel
   reader, driven by the event list in the input vector file */
`timescale 1ns/1ns

module tb_ad9228_single_ch_read;

    logic clk, arst_n, read_en, din_p, din_n, fco, dco, fifo_rd_en, fifo_rd_clk;
    logic fifo_not_empty, fifo_full;
    adc_pkg::sample_t fifo_dout;

    int    v_test[$];         // one entry per vector line
    string v_cmd[$];
    int    v_val[$];
    int    v_cnt[$];
    int    exp_q[$];          // words still owed by the DUT in arrival order
    bit    loaded = 0;
    bit    hold_reads = 0;    // host stops reading while set
    bit    want_read_en = 1;  // level the host puts on read_en
    bit    model_read_en = 1; // read_en level in force for the words now sent
    bit    in_lock = 0;       // tracker expected to be in frame
    bit    held_mode = 0;
    int    held_count = 0;    // accepted words sitting unread during a hold
    int    error_count = 0;
    int    check_count = 0;
    int    test_count = 0;
    int    reads_in_test = 0;
    int    cur_test = 0;

    ad9228_single_ch_read dut0 (
        .clk(clk), .arst_n(arst_n), .read_en(read_en), .din_p(din_p), .din_n(din_n),
        .fco(fco), .dco(dco), .fifo_rd_en(fifo_rd_en), .fifo_rd_clk(fifo_rd_clk),
        .fifo_not_empty(fifo_not_empty), .fifo_full(fifo_full), .fifo_dout(fifo_dout)
    );

    initial begin
        clk = 0;
        forever #50 clk = ~clk;
    end

    initial begin
        dco = 0;
        forever #100 dco = ~dco;
    end

    initial begin
        fifo_rd_clk = 0;
        forever #75 fifo_rd_clk = ~fifo_rd_clk;
    end

    task automatic compare_value(input string name, input int got, input int exp);
        check_count++;
        assert (got == exp) else begin
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    // drives one bit pair and the earlier bit lands before the falling edge
    task automatic drive_pair(input bit early, input bit late, input bit f);
        @(posedge dco);
        #10;
        din_p = early;
        din_n = ~early;
        fco   = f;
        @(negedge dco);
        #10;
        din_p = late;
        din_n = ~late;
    endtask

    task automatic drive_idle(input int pairs);
        want_read_en = model_read_en;
        for (int p = 0; p < pairs; p++) drive_pair(1'b0, 1'b0, 1'b0);  // fco low all along
    endtask

    task automatic send_word(input logic [11:0] value);
        if (!in_lock) begin
            in_lock = 1;  // this word is spent finding the frame
        end else if (model_read_en && (!held_mode || held_count < 16)) begin
            exp_q.push_back(value);
            if (held_mode) held_count++;
        end
        for (int p = 0; p < 6; p++) begin
            if (p == 3) want_read_en = model_read_en;  // clear of the previous word's write
            drive_pair(value[11-2*p], value[10-2*p], p < 3);
        end
    endtask

    task automatic finish_test();
        int errors_before;
        errors_before = error_count;
        drive_idle(2);
        in_lock = 0;  // a quiet fco line drops the frame
        while (exp_q.size() != 0) @(posedge clk);
        repeat (40) @(posedge clk);
        check_count++;
        assert (!fifo_not_empty) else begin
            $display("test %0d: the FIFO still holds words that were never sent for it",
                     cur_test);
            error_count++;
        end
        test_count++;
        $display("test %0d: %0d words read, %s", cur_test, reads_in_test,
                 (error_count == errors_before) ? "ok" : "failed");
        reads_in_test = 0;
    endtask

    // reads the event list and keeps only lines that carry all four fields
    function automatic bit load_vectors();
        int fd, n, t, v, k;
        string line, c;
        fd = $fopen("bench/adc_input_vectors.txt", "r");
        if (fd == 0) begin
            return 0;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 2 && line[0] != "#") begin
                n = $sscanf(line, "%d %s %h %d", t, c, v, k);
                if (n == 4) begin
                    v_test.push_back(t);
                    v_cmd.push_back(c);
                    v_val.push_back(v);
                    v_cnt.push_back(k);
                end
            end
        end
        $fclose(fd);
        return 1;
    endfunction

    task automatic run_tests();
        repeat (5) @(posedge clk);
        #10;
        arst_n = 1;
        repeat (4) @(posedge clk);
        compare_value("fifo_not_empty", fifo_not_empty, 0);
        compare_value("fifo_full", fifo_full, 0);
        compare_value("fifo_dout", fifo_dout, 0);
        foreach (v_test[i]) begin
            if (v_test[i] != cur_test) begin
                if (cur_test != 0) finish_test();
                cur_test = v_test[i];
            end
            case (v_cmd[i])
                "word": begin
                    for (int j = 0; j < v_cnt[i]; j++) begin
                        send_word(12'(v_val[i] + j * 12'h2f1));
                    end
                end
                "slip": begin
                    drive_idle(3);  // half a word with fco low where it should be high
                    in_lock = 0;
                end
                "rden": model_read_en = v_val[i][0];
                "hold": begin
                    hold_reads = 1;
                    held_mode  = 1;
                    held_count = 0;
                end
                "release": begin
                    repeat (10) @(posedge clk);  // last write settles into the full flag
                    compare_value("fifo_full", fifo_full, held_count == 16);
                    in_lock    = 0;
                    hold_reads = 0;
                    held_mode  = 0;
                end
                default: ;
            endcase
        end
    endtask

    // read_en follows the clk edge like any other host output
    initial begin
        forever begin
            @(posedge clk);
            #10;
            read_en = want_read_en;
        end
    end

    // the host reads while words wait and checks each one an edge after its read
    initial begin
        bit last_fire;
        last_fire = 0;
        forever begin
            @(posedge fifo_rd_clk);
            #10;
            if (last_fire) begin
                reads_in_test++;
                check_count++;
                assert (exp_q.size() != 0) else begin
                    $display("%0t ns: word %h was read but none was expected",
                             $time, fifo_dout);
                    error_count++;
                end
                if (exp_q.size() != 0) compare_value("fifo_dout", fifo_dout, exp_q.pop_front());
            end
            fifo_rd_en = fifo_not_empty && !hold_reads;
            last_fire  = fifo_rd_en && fifo_not_empty;
        end
    end

    // run length grows with the events in the file
    initial begin
        longint events;
        events = 0;
        wait (loaded);
        foreach (v_cnt[i]) events += (v_cnt[i] > 1) ? v_cnt[i] : 1;
        #(events * 12 * 200 + 200 * 100);
        $display("watchdog: the run took longer than the tests allow and was stopped");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        arst_n     = 0;
        read_en    = 0;
        din_p      = 0;
        din_n      = 1;
        fco        = 0;
        fifo_rd_en = 0;
        loaded     = load_vectors();
        if (!loaded) begin
            $display("could not open the input vector file");
            $display(">>> FAIL");
            $finish;
        end else begin
            run_tests();
            $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
            if (error_count == 0) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

endmodule

// ==== bench/adc_input_vectors.txt ====
# test command value count, all values hex, a word line sends count words
# starting at value and stepping by 2f1, commands word slip rden hold release end
1 word 5a5 1
2 word 800 21
3 word 123 4
3 rden 0 0
3 word 456 5
3 rden 1 0
3 word 789 5
4 word abc 6
4 slip 000 0
4 word def 8
5 hold 000 0
5 word 0f0 21
5 release 000 0
0 end 000 0

// ==== flist.f ====
+incdir+src
src/adc_pkg.sv
src/fifo_pkg.sv
src/serial_shifter.sv
src/frame_tracker.sv
src/word_assembler.sv
src/sample_fifo_async.sv
src/ad9228_single_ch_read.sv
bench/tb_ad9228_single_ch_read.sv

// ==== Bender.yml ====
package:
  name: ad9228_single_ch_read

export_include_dirs:
  - src

sources:
  - src/adc_pkg.sv
  - src/fifo_pkg.sv
  - src/serial_shifter.sv
  - src/frame_tracker.sv
  - src/word_assembler.sv
  - src/sample_fifo_async.sv
  - src/ad9228_single_ch_read.sv
  - target: simulation
    files:
      - bench/tb_ad9228_single_ch_read.sv
